//--- src/sifhCfgPkg.sv
package sifhCfgPkg;

    // lane geometry
    localparam int LANES           = 2;
    localparam int PIXELS_PER_LANE = 4;
    localparam int PIXEL_BITS      = 2;

    // histogram shape, bin taken from the top of the timestamp
    localparam int BINS      = 16;
    localparam int BIN_BITS  = 4;
    localparam int TIME_BITS = 12;

    localparam int COUNT_BITS = 8;
    localparam int COUNT_MAX  = 255;    // counts stick here

    // memory word address is {pixel, bin}
    localparam int ADDR_BITS = PIXEL_BITS + BIN_BITS;
    localparam int DEPTH     = PIXELS_PER_LANE * BINS;

    // pixel index across all lanes
    localparam int GPIX_BITS = $clog2(LANES * PIXELS_PER_LANE);

endpackage

//--- src/sifhTypesPkg.sv
package sifhTypesPkg;

    // one photon hit as seen by a lane
    typedef struct packed {
        logic                                 valid;
        logic [sifhCfgPkg::PIXEL_BITS-1:0]    pixel;
        logic [sifhCfgPkg::TIME_BITS-1:0]     stamp;
    } photonEvent;

    // peak of one pixel, pixel index local to the lane
    typedef struct packed {
        logic                                 valid;
        logic [sifhCfgPkg::PIXEL_BITS-1:0]    pixel;
        logic [sifhCfgPkg::BIN_BITS-1:0]      bin;
        logic [sifhCfgPkg::COUNT_BITS-1:0]    count;
    } lanePeak;

    // merged result, pixel index is global
    typedef struct packed {
        logic                                 valid;
        logic [sifhCfgPkg::GPIX_BITS-1:0]     pixel;
        logic [sifhCfgPkg::BIN_BITS-1:0]      bin;
        logic [sifhCfgPkg::COUNT_BITS-1:0]    count;
    } pixelResult;

    // strongest peak of a frame
    typedef struct packed {
        logic                                 valid;
        logic [sifhCfgPkg::GPIX_BITS-1:0]     pixel;
        logic [sifhCfgPkg::BIN_BITS-1:0]      bin;
        logic [sifhCfgPkg::COUNT_BITS-1:0]    count;
    } frameSummary;

endpackage

//--- src/histRam.sv
`timescale 1ns/1ps

module histRam (
    input  logic                                clk,
    input  logic                                wrEn,
    input  logic [sifhCfgPkg::ADDR_BITS-1:0]    wrAddr,
    input  logic [sifhCfgPkg::COUNT_BITS-1:0]   wrData,
    input  logic                                rdEn,
    input  logic [sifhCfgPkg::ADDR_BITS-1:0]    rdAddr,
    output logic [sifhCfgPkg::COUNT_BITS-1:0]   rdData
);

    logic [sifhCfgPkg::COUNT_BITS-1:0] mem [sifhCfgPkg::DEPTH];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, same-address write in the same cycle gives old data
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

    // an unknown address would corrupt a whole pixel histogram
    assert property (@(posedge clk) wrEn |-> !$isunknown(wrAddr))
        else $error("histRam: write address unknown while wrEn is high");

    assert property (@(posedge clk) rdEn |-> !$isunknown(rdAddr))
        else $error("histRam: read address unknown while rdEn is high");

endmodule

//--- src/histEngine.sv
`timescale 1ns/1ps

module histEngine (
    input  logic                                clk,
    input  logic                                res,
    input  sifhTypesPkg::photonEvent            evt,
    input  logic                                frameEnd,
    output logic                                ready,
    output logic                                wrEn,
    output logic                                rdEn,
    output logic [sifhCfgPkg::ADDR_BITS-1:0]    wrAddr,
    output logic [sifhCfgPkg::ADDR_BITS-1:0]    rdAddr,
    output logic [sifhCfgPkg::COUNT_BITS-1:0]   wrData,
    input  logic [sifhCfgPkg::COUNT_BITS-1:0]   rdData,
    output sifhTypesPkg::lanePeak               peak
);

    typedef enum logic [1:0] {
        stClear,
        stAccum,
        stDrain,
        stScan
    } engState;

    engState state;
    logic [sifhCfgPkg::ADDR_BITS:0] addrCnt;   // spare bit covers the scan tail

    // accumulate pipeline
    logic                                 accept;
    logic [sifhCfgPkg::ADDR_BITS-1:0]     evtAddr;
    logic                                 s1Vld;      // event waiting for its write
    logic [sifhCfgPkg::ADDR_BITS-1:0]     s1Addr;
    logic                                 fwdVld;     // write of the previous cycle
    logic [sifhCfgPkg::ADDR_BITS-1:0]     fwdAddr;
    logic [sifhCfgPkg::COUNT_BITS-1:0]    fwdData;
    logic [sifhCfgPkg::COUNT_BITS-1:0]    base;
    logic [sifhCfgPkg::COUNT_BITS-1:0]    incr;

    // scan
    logic                                 scanRd;
    logic                                 scanVld;    // rdData holds a scan word
    logic [sifhCfgPkg::ADDR_BITS-1:0]     scanAddrQ;
    logic [sifhCfgPkg::BIN_BITS-1:0]      curBin;
    logic [sifhCfgPkg::PIXEL_BITS-1:0]    curPix;
    logic                                 newMax;
    logic [sifhCfgPkg::COUNT_BITS-1:0]    maxCnt;
    logic [sifhCfgPkg::BIN_BITS-1:0]      maxBin;

    logic                                 peakVld;
    logic [sifhCfgPkg::PIXEL_BITS-1:0]    peakPix;
    logic [sifhCfgPkg::BIN_BITS-1:0]      peakBin;
    logic [sifhCfgPkg::COUNT_BITS-1:0]    peakCnt;

    assign accept  = evt.valid & ready;
    assign evtAddr = {evt.pixel, evt.stamp[sifhCfgPkg::TIME_BITS-1 -: sifhCfgPkg::BIN_BITS]};
    assign scanRd  = (state == stScan) && (addrCnt < (sifhCfgPkg::ADDR_BITS + 1)'(sifhCfgPkg::DEPTH));

    // scan reads take the port, events cannot arrive then anyway
    always_comb begin
        if (scanRd) begin
            rdEn   = 1'b1;
            rdAddr = addrCnt[sifhCfgPkg::ADDR_BITS-1:0];
        end else begin
            rdEn   = accept;
            rdAddr = evtAddr;
        end
    end

    // back-to-back hit on the same bin, memory data is one write behind
    assign base = (fwdVld && fwdAddr == s1Addr) ? fwdData : rdData;
    assign incr = (base == sifhCfgPkg::COUNT_BITS'(sifhCfgPkg::COUNT_MAX)) ? base : base + 1'b1;

    always_comb begin
        if (state == stClear) begin
            wrEn   = 1'b1;
            wrAddr = addrCnt[sifhCfgPkg::ADDR_BITS-1:0];
            wrData = '0;
        end else begin
            wrEn   = s1Vld;
            wrAddr = s1Addr;
            wrData = incr;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= stClear;
            addrCnt <= '0;
            ready   <= 1'b0;
        end else begin
            case (state)
                stClear: begin
                    addrCnt <= addrCnt + 1'b1;
                    if (addrCnt == (sifhCfgPkg::ADDR_BITS + 1)'(sifhCfgPkg::DEPTH - 1)) begin
                        state   <= stAccum;
                        addrCnt <= '0;
                        ready   <= 1'b1;
                    end
                end
                stAccum: begin
                    if (frameEnd && ready) begin
                        state <= stDrain;
                        ready <= 1'b0;
                    end
                end
                stDrain: state <= stScan;   // last event write lands here
                stScan: begin
                    addrCnt <= addrCnt + 1'b1;
                    // two extra cycles let the last peak leave before clearing
                    if (addrCnt == (sifhCfgPkg::ADDR_BITS + 1)'(sifhCfgPkg::DEPTH + 1)) begin
                        state   <= stClear;
                        addrCnt <= '0;
                    end
                end
                default: state <= stClear;
            endcase
        end
    end

    assign curBin = scanAddrQ[sifhCfgPkg::BIN_BITS-1:0];
    assign curPix = scanAddrQ[sifhCfgPkg::ADDR_BITS-1:sifhCfgPkg::BIN_BITS];
    // strict compare so ties keep the lower bin
    assign newMax = (curBin == '0) || (rdData > maxCnt);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Vld   <= 1'b0;
            fwdVld  <= 1'b0;
            scanVld <= 1'b0;
            peakVld <= 1'b0;
        end else begin
            s1Vld   <= accept;
            fwdVld  <= s1Vld;
            scanVld <= scanRd;
            peakVld <= scanVld && (curBin == sifhCfgPkg::BIN_BITS'(sifhCfgPkg::BINS - 1));
        end
    end

    always_ff @(posedge clk) begin
        s1Addr    <= evtAddr;
        fwdAddr   <= s1Addr;
        fwdData   <= incr;
        scanAddrQ <= addrCnt[sifhCfgPkg::ADDR_BITS-1:0];
        if (scanVld && newMax) begin
            maxCnt <= rdData;
            maxBin <= curBin;
        end
        peakPix <= curPix;
        peakBin <= newMax ? curBin : maxBin;     // bin 15 may still win
        peakCnt <= newMax ? rdData : maxCnt;
    end

    assign peak = '{valid: peakVld, pixel: peakPix, bin: peakBin, count: peakCnt};

    assert property (@(posedge clk) disable iff (!res) peak.valid |-> state == stScan)
        else $error("histEngine: peak pulse outside the scan pass");

    assert property (@(posedge clk) disable iff (!res) state == stClear |-> !ready)
        else $error("histEngine: ready high during the clear pass");

endmodule

//--- src/peakMerge.sv
`timescale 1ns/1ps

module peakMerge (
    input  logic                        clk,
    input  logic                        res,
    input  sifhTypesPkg::lanePeak       lanePk [sifhCfgPkg::LANES],
    output sifhTypesPkg::pixelResult    result,
    output sifhTypesPkg::frameSummary   summary
);

    logic [sifhCfgPkg::LANES-1:0]       holdVld;
    sifhTypesPkg::lanePeak              holdPk [sifhCfgPkg::LANES];
    logic [sifhCfgPkg::LANES-1:0]       grant;
    sifhTypesPkg::lanePeak              selPk;
    logic [sifhCfgPkg::GPIX_BITS-1:0]   selBase;    // first global pixel of the lane
    logic                               resVld;
    logic [sifhCfgPkg::GPIX_BITS-1:0]   resPix;

    logic [sifhCfgPkg::GPIX_BITS-1:0]   resCnt;     // results so far in this frame
    logic                               lastRes;
    logic                               candBetter;
    logic [sifhCfgPkg::GPIX_BITS-1:0]   bestPix;
    logic [sifhCfgPkg::BIN_BITS-1:0]    bestBin;
    logic [sifhCfgPkg::COUNT_BITS-1:0]  bestCnt;
    logic                               sumVld;
    logic [sifhCfgPkg::GPIX_BITS-1:0]   sumPix;
    logic [sifhCfgPkg::BIN_BITS-1:0]    sumBin;
    logic [sifhCfgPkg::COUNT_BITS-1:0]  sumCnt;

    // lowest full lane wins
    always_comb begin
        grant   = '0;
        selPk   = holdPk[0];
        selBase = '0;
        for (int i = sifhCfgPkg::LANES - 1; i >= 0; i--) begin
            if (holdVld[i]) begin
                grant    = '0;
                grant[i] = 1'b1;
                selPk    = holdPk[i];
                selBase  = sifhCfgPkg::GPIX_BITS'(i * sifhCfgPkg::PIXELS_PER_LANE);
            end
        end
    end

    assign resVld = |holdVld;
    assign resPix = selBase + sifhCfgPkg::GPIX_BITS'(selPk.pixel);
    assign result = '{valid: resVld, pixel: resPix, bin: selPk.bin, count: selPk.count};

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            holdVld <= '0;
        end else begin
            for (int i = 0; i < sifhCfgPkg::LANES; i++) begin
                if (lanePk[i].valid) begin
                    holdVld[i] <= 1'b1;
                end else if (grant[i]) begin
                    holdVld[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < sifhCfgPkg::LANES; i++) begin
            if (lanePk[i].valid) begin
                holdPk[i] <= lanePk[i];
            end
        end
    end

    assign lastRes = resCnt == sifhCfgPkg::GPIX_BITS'(sifhCfgPkg::LANES * sifhCfgPkg::PIXELS_PER_LANE - 1);
    // first result of a frame always takes the lead, ties go to the lower pixel
    assign candBetter = (resCnt == '0) || (selPk.count > bestCnt)
                     || (selPk.count == bestCnt && resPix < bestPix);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            resCnt <= '0;
            sumVld <= 1'b0;
        end else begin
            sumVld <= resVld && lastRes;
            if (resVld) begin
                resCnt <= resCnt + 1'b1;    // wraps to zero after the eighth
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resVld && candBetter) begin
            bestPix <= resPix;
            bestBin <= selPk.bin;
            bestCnt <= selPk.count;
        end
        if (resVld && lastRes) begin
            sumPix <= candBetter ? resPix : bestPix;
            sumBin <= candBetter ? selPk.bin : bestBin;
            sumCnt <= candBetter ? selPk.count : bestCnt;
        end
    end

    assign summary = '{valid: sumVld, pixel: sumPix, bin: sumBin, count: sumCnt};

    for (genvar g = 0; g < sifhCfgPkg::LANES; g++) begin : gHoldChk
        assert property (@(posedge clk) disable iff (!res)
                lanePk[g].valid |-> !holdVld[g] || grant[g])
            else $error("peakMerge: lane %0d peak arrived while its hold was full", g);
    end

endmodule

//--- src/sifhTop.sv
`timescale 1ns/1ps

module sifhTop (
    input  logic                            clk,
    input  logic                            res,
    input  sifhTypesPkg::photonEvent        evt [sifhCfgPkg::LANES],
    input  logic                            frameEnd,
    output logic [sifhCfgPkg::LANES-1:0]    ready,
    output sifhTypesPkg::pixelResult        result,
    output sifhTypesPkg::frameSummary       summary
);

    logic                               frameTake;
    logic [sifhCfgPkg::LANES-1:0]       wrEn;
    logic [sifhCfgPkg::LANES-1:0]       rdEn;
    logic [sifhCfgPkg::ADDR_BITS-1:0]   wrAddr [sifhCfgPkg::LANES];
    logic [sifhCfgPkg::ADDR_BITS-1:0]   rdAddr [sifhCfgPkg::LANES];
    logic [sifhCfgPkg::COUNT_BITS-1:0]  wrData [sifhCfgPkg::LANES];
    logic [sifhCfgPkg::COUNT_BITS-1:0]  rdData [sifhCfgPkg::LANES];
    sifhTypesPkg::lanePeak              lanePk [sifhCfgPkg::LANES];

    // frame end only counts once every lane is accumulating
    assign frameTake = frameEnd & (&ready);

    for (genvar g = 0; g < sifhCfgPkg::LANES; g++) begin : gLane
        histEngine u_histEngine (
            .clk      (clk),
            .res      (res),
            .evt      (evt[g]),
            .frameEnd (frameTake),
            .ready    (ready[g]),
            .wrEn     (wrEn[g]),
            .rdEn     (rdEn[g]),
            .wrAddr   (wrAddr[g]),
            .rdAddr   (rdAddr[g]),
            .wrData   (wrData[g]),
            .rdData   (rdData[g]),
            .peak     (lanePk[g])
        );

        histRam u_histRam (
            .clk    (clk),
            .wrEn   (wrEn[g]),
            .wrAddr (wrAddr[g]),
            .wrData (wrData[g]),
            .rdEn   (rdEn[g]),
            .rdAddr (rdAddr[g]),
            .rdData (rdData[g])
        );
    end

    peakMerge u_peakMerge (
        .clk     (clk),
        .res     (res),
        .lanePk  (lanePk),
        .result  (result),
        .summary (summary)
    );

endmodule

//--- bench/sifhChecker.sv
`timescale 1ns/1ps

module sifhChecker (
    input  logic                            clk,
    input  logic                            res,
    input  logic [sifhCfgPkg::LANES-1:0]    ready,
    input  sifhTypesPkg::pixelResult        result,
    input  sifhTypesPkg::frameSummary       summary
);

    sifhTypesPkg::pixelResult   expRes [$];
    sifhTypesPkg::frameSummary  expSum [$];
    int resCount = 0;
    int sumCount = 0;
    int errCount = 0;
    int testCount = 0;
    int testErrBase = 0;    // errors before the running test

    task automatic expectResult(input sifhTypesPkg::pixelResult r);
        expRes.push_back(r);
    endtask

    task automatic expectSummary(input sifhTypesPkg::frameSummary s);
        expSum.push_back(s);
    endtask

    task automatic endTest(input string name, input bit timedOut);
        testCount++;
        if (errCount == testErrBase && !timedOut) begin
            $display("test %0d %s: pass", testCount, name);
        end else begin
            $display("test %0d %s: fail, %0d errors%s", testCount, name,
                     errCount - testErrBase, timedOut ? ", timed out" : "");
        end
        testErrBase = errCount;
    endtask

    task automatic checkResult();
        sifhTypesPkg::pixelResult e;
        if (result.valid !== 1'b1) begin
            if (result.valid !== 1'b0) begin
                $display("ERR %0t: result valid unknown", $time);
                errCount++;
            end
        end else if (expRes.size() == 0) begin
            $display("ERR %0t: unexpected result for pixel %0d", $time, result.pixel);
            errCount++;
        end else begin
            e = expRes.pop_front();
            resCount++;
            if (result.pixel !== e.pixel || result.bin !== e.bin || result.count !== e.count) begin
                $display("ERR %0t: result got pixel %0d bin %0d count %0d, expected %0d %0d %0d",
                         $time, result.pixel, result.bin, result.count,
                         e.pixel, e.bin, e.count);
                errCount++;
            end
        end
    endtask

    task automatic checkSummary();
        sifhTypesPkg::frameSummary e;
        if (summary.valid !== 1'b1) begin
            if (summary.valid !== 1'b0) begin
                $display("ERR %0t: summary valid unknown", $time);
                errCount++;
            end
        end else if (expSum.size() == 0) begin
            $display("ERR %0t: unexpected summary", $time);
            errCount++;
        end else begin
            e = expSum.pop_front();
            sumCount++;
            if (summary.pixel !== e.pixel || summary.bin !== e.bin
                    || summary.count !== e.count) begin
                $display("ERR %0t: summary got pixel %0d bin %0d count %0d, expected %0d %0d %0d",
                         $time, summary.pixel, summary.bin, summary.count,
                         e.pixel, e.bin, e.count);
                errCount++;
            end
        end
    endtask

    // flop driven outputs still hold the previous cycle here
    always @(posedge clk) begin
        if (!res) begin
            if (ready !== '0 || result.valid !== 1'b0 || summary.valid !== 1'b0) begin
                $display("ERR %0t: outputs not idle during reset", $time);
                errCount++;
            end
        end else begin
            checkResult();
            checkSummary();
        end
    end

endmodule

//--- bench/sifhTb.sv
`timescale 1ns/1ps

module sifhTb;

    localparam int SEED         = 18;
    localparam int TIMEOUT      = 500;      // cycles per wait
    localparam int EVENTS       = 200;      // per lane in a random frame
    localparam int WAIT_READY   = 0;
    localparam int WAIT_RESULTS = 1;
    localparam int WAIT_SUMMARY = 2;

    logic                               clk;
    logic                               res;
    sifhTypesPkg::photonEvent           evt [sifhCfgPkg::LANES];
    logic                               frameEnd;
    logic [sifhCfgPkg::LANES-1:0]       ready;
    sifhTypesPkg::pixelResult           result;
    sifhTypesPkg::frameSummary          summary;

    sifhTypesPkg::photonEvent           nextEvt [sifhCfgPkg::LANES];
    logic [31:0]                        rngState;
    int hist [sifhCfgPkg::LANES][sifhCfgPkg::PIXELS_PER_LANE][sifhCfgPkg::BINS];
    int                                 timeouts;

    sifhTop u_sifhTop (
        .clk      (clk),
        .res      (res),
        .evt      (evt),
        .frameEnd (frameEnd),
        .ready    (ready),
        .result   (result),
        .summary  (summary)
    );

    sifhChecker u_sifhChecker (
        .clk     (clk),
        .res     (res),
        .ready   (ready),
        .result  (result),
        .summary (summary)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // bin on top of random low timestamp bits
    function automatic sifhTypesPkg::photonEvent makeHit(input int pix, input int bin);
        sifhTypesPkg::photonEvent e;
        logic [31:0] r;
        r = nextRand();
        e.valid = 1'b1;
        e.pixel = sifhCfgPkg::PIXEL_BITS'(pix);
        e.stamp = {sifhCfgPkg::BIN_BITS'(bin),
                   r[sifhCfgPkg::TIME_BITS-sifhCfgPkg::BIN_BITS-1:0]};
        return e;
    endfunction

    task automatic clearModel();
        foreach (hist[l, p, b]) hist[l][p][b] = 0;
    endtask

    // drive one clock of events and count them in the model
    task automatic issueCycle();
        int bin;
        @(posedge clk);
        for (int l = 0; l < sifhCfgPkg::LANES; l++) begin
            evt[l] <= nextEvt[l];
            if (nextEvt[l].valid) begin
                bin = nextEvt[l].stamp[sifhCfgPkg::TIME_BITS-1 -: sifhCfgPkg::BIN_BITS];
                if (hist[l][nextEvt[l].pixel][bin] < sifhCfgPkg::COUNT_MAX) begin
                    hist[l][nextEvt[l].pixel][bin]++;
                end
            end
            nextEvt[l].valid = 1'b0;
        end
    endtask

    // first bin holding the maximum
    function automatic sifhTypesPkg::pixelResult peakOf(input int l, input int p);
        sifhTypesPkg::pixelResult r;
        int best;
        int bestBin;
        best = hist[l][p][0];
        bestBin = 0;
        for (int b = 1; b < sifhCfgPkg::BINS; b++) begin
            if (hist[l][p][b] > best) begin
                best = hist[l][p][b];
                bestBin = b;
            end
        end
        r.valid = 1'b1;
        r.pixel = sifhCfgPkg::GPIX_BITS'(l * sifhCfgPkg::PIXELS_PER_LANE + p);
        r.bin   = sifhCfgPkg::BIN_BITS'(bestBin);
        r.count = sifhCfgPkg::COUNT_BITS'(best);
        return r;
    endfunction

    task automatic pushExpected();
        sifhTypesPkg::pixelResult r;
        sifhTypesPkg::frameSummary s;
        int bestCnt;
        bestCnt = -1;
        s = '0;
        // lanes scan in lockstep and lane 0 leaves the merger first
        for (int p = 0; p < sifhCfgPkg::PIXELS_PER_LANE; p++) begin
            for (int l = 0; l < sifhCfgPkg::LANES; l++) begin
                u_sifhChecker.expectResult(peakOf(l, p));
            end
        end
        for (int g = 0; g < sifhCfgPkg::LANES * sifhCfgPkg::PIXELS_PER_LANE; g++) begin
            r = peakOf(g / sifhCfgPkg::PIXELS_PER_LANE, g % sifhCfgPkg::PIXELS_PER_LANE);
            if (int'(r.count) > bestCnt) begin   // strict so the lower pixel keeps a tie
                bestCnt = r.count;
                s = r;
            end
        end
        u_sifhChecker.expectSummary(s);
    endtask

    function automatic bit reached(input int which, input int target);
        case (which)
            WAIT_READY:   return ready == '1;
            WAIT_RESULTS: return u_sifhChecker.resCount >= target;
            default:      return u_sifhChecker.sumCount >= target;
        endcase
    endfunction

    task automatic waitFor(input int which, input int target, input string what);
        int n;
        n = 0;
        while (!reached(which, target) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!reached(which, target)) begin
            $display("timeout: %s never arrived", what);
            timeouts++;
        end
    endtask

    task automatic runFrame();
        int resGoal;
        resGoal = u_sifhChecker.resCount + sifhCfgPkg::LANES * sifhCfgPkg::PIXELS_PER_LANE;
        pushExpected();
        issueCycle();   // idle cycle clears the event bus
        @(posedge clk);
        frameEnd <= 1'b1;
        @(posedge clk);
        frameEnd <= 1'b0;
        waitFor(WAIT_RESULTS, resGoal, "the 8 pixel results");
        if (timeouts == 0) waitFor(WAIT_SUMMARY, u_sifhChecker.sumCount + 1, "the frame summary");
        if (timeouts == 0) waitFor(WAIT_READY, 0, "lane ready after the clear pass");
        clearModel();
    endtask

    task automatic randomFrame();
        int left [sifhCfgPkg::LANES];
        logic [31:0] r;
        foreach (left[l]) left[l] = EVENTS;
        while (left[0] > 0 || left[1] > 0) begin
            for (int l = 0; l < sifhCfgPkg::LANES; l++) begin
                r = nextRand();
                if (left[l] > 0 && r[0]) begin
                    nextEvt[l] = makeHit(r[2:1], r[6:3]);
                    left[l]--;
                end
            end
            issueCycle();
        end
    endtask

    task automatic forwardBursts();
        for (int i = 0; i < 40; i++) begin
            nextEvt[0] = makeHit(1, 5);
            nextEvt[1] = makeHit(3, 12);
            issueCycle();
        end
        for (int i = 0; i < 30; i++) begin
            nextEvt[0] = makeHit(0, 2 + i % 2);
            nextEvt[1] = makeHit(2, 8 + i % 2);
            issueCycle();
        end
        for (int i = 0; i < 30; i++) begin
            if (i % 3 != 2) begin   // same-bin pairs with a gap
                nextEvt[0] = makeHit(1, 5);
                nextEvt[1] = makeHit(3, 12);
            end
            issueCycle();
        end
    endtask

    task automatic saturateBin();
        logic [31:0] r;
        for (int i = 0; i < 300; i++) begin
            r = nextRand();
            nextEvt[0] = makeHit(2, 7);
            if (r[4]) nextEvt[1] = makeHit(1, r[3:0]);
            issueCycle();
        end
    endtask

    // global pixels 3 and 4 tie and pixel 1 ties bins 4 and 9
    task automatic tiePeaks();
        for (int i = 0; i < 20; i++) begin
            nextEvt[0] = makeHit(3, 6);
            nextEvt[1] = makeHit(0, 10);
            issueCycle();
        end
        for (int i = 0; i < 20; i++) begin
            nextEvt[0] = makeHit(1, (i % 2) ? 9 : 4);
            issueCycle();
        end
    endtask

    initial begin
        clk = 1'b0;
        res = 1'b0;
        frameEnd = 1'b0;
        timeouts = 0;
        rngState = SEED;
        for (int l = 0; l < sifhCfgPkg::LANES; l++) begin
            evt[l] = '0;
            nextEvt[l] = '0;
        end
        clearModel();
        repeat (2) @(posedge clk);
        res <= 1'b1;
        waitFor(WAIT_READY, 0, "lane ready after reset");
        u_sifhChecker.endTest("reset and first clear", timeouts != 0);
        if (timeouts == 0) begin
            randomFrame();
            runFrame();
            u_sifhChecker.endTest("random frame", timeouts != 0);
        end
        if (timeouts == 0) begin
            forwardBursts();
            runFrame();
            u_sifhChecker.endTest("same-bin forwarding", timeouts != 0);
        end
        if (timeouts == 0) begin
            saturateBin();
            runFrame();
            u_sifhChecker.endTest("count saturation", timeouts != 0);
        end
        if (timeouts == 0) begin
            tiePeaks();
            runFrame();
            u_sifhChecker.endTest("summary and bin ties", timeouts != 0);
        end
        if (timeouts == 0) begin
            randomFrame();
            runFrame();
            u_sifhChecker.endTest("second random frame", timeouts != 0);
        end
        $display("results %0d, summaries %0d, errors %0d, timeouts %0d",
                 u_sifhChecker.resCount, u_sifhChecker.sumCount,
                 u_sifhChecker.errCount, timeouts);
        if (u_sifhChecker.errCount == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sifh.f
src/sifhCfgPkg.sv
src/sifhTypesPkg.sv
src/histRam.sv
src/histEngine.sv
src/peakMerge.sv
src/sifhTop.sv
bench/sifhChecker.sv
bench/sifhTb.sv

//--- Bender.yml
package:
  name: sifh

sources:
  - src/sifhCfgPkg.sv
  - src/sifhTypesPkg.sv
  - src/histRam.sv
  - src/histEngine.sv
  - src/peakMerge.sv
  - src/sifhTop.sv
  - target: simulation
    files:
      - bench/sifhChecker.sv
      - bench/sifhTb.sv
